// ==== all.f ====
verilog/lsi_isa_pkg.sv
verilog/lsi_ctrl_pkg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/cond_codes.sv
verilog/sequencer.sv
verilog/lsi_core.sv
verification/lsi_core_assert.sv
verification/lsi_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lsi_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsi_core_tb \
	-f all.f -Mdir obj_dir -o lsi_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/lsi_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// ==== verification/lsi_core_assert.sv ====
`timescale 1ns/10ps

module lsi_core_assert (
	input logic                      clkdbi,
	input logic                      reset_n,
	input logic                      instr_strobe,
	input logic                      done,
	input lsi_ctrl_pkg::seq_state_t  state
);

	logic accept;

	assign accept = instr_strobe && (state == lsi_ctrl_pkg::IDLE);

	a_done_single: assert property (@(posedge clkdbi) disable iff (!reset_n)
		done |-> !$past(done))
		else $error("done high on two consecutive cycles");

	// exactly three cycles from accepted strobe to done
	a_done_latency: assert property (@(posedge clkdbi) disable iff (!reset_n)
		done == $past(accept, 3))
		else $error("done not three cycles after an accepted strobe");

	a_reset_done: assert property (@(posedge clkdbi) $past(!reset_n) |-> !done)
		else $error("done high during reset");

	a_strobe_idle: assert property (@(posedge clkdbi) disable iff (!reset_n)
		instr_strobe |-> (state == lsi_ctrl_pkg::IDLE))
		else $error("strobe while an instruction is running");

endmodule

bind sequencer lsi_core_assert u_assert (
	.clkdbi       (clkdbi),
	.reset_n      (reset_n),
	.instr_strobe (instr_strobe),
	.done         (done),
	.state        (state)
);

// ==== verification/lsi_core_tb.sv ====
`timescale 1ns/10ps

module lsi_core_tb;

	localparam lsi_isa_pkg::word_t START_PC = 16'o001000;
	localparam int RESET_CYCLES = 2;
	localparam int MAX_WAIT = 8;        // cycles from strobe to done, with margin

	typedef struct packed {
		lsi_isa_pkg::word_t instr;
		lsi_isa_pkg::word_t lit;
		lsi_isa_pkg::word_t res;
		lsi_isa_pkg::cc_t   cc;
		lsi_isa_pkg::word_t pc;
	} row_t;

	logic               clkdbi;
	logic               reset_n;
	logic               instr_strobe;
	logic               done;
	lsi_isa_pkg::word_t instr;
	lsi_isa_pkg::word_t literal;
	lsi_isa_pkg::word_t result;
	lsi_isa_pkg::word_t pc;
	lsi_isa_pkg::cc_t   flags;

	row_t               rows[$];
	lsi_isa_pkg::word_t m_reg [0:7];   // reference registers, m_reg[7] is the pc
	lsi_isa_pkg::cc_t   m_cc;
	logic [31:0]        lfsr_q;
	logic               built;
	int                 cur_row;

	lsi_core #(
		.RESET_PC (START_PC)
	) u_dut (
		.clkdbi       (clkdbi),
		.reset_n      (reset_n),
		.instr_strobe (instr_strobe),
		.instr        (instr),
		.literal      (literal),
		.done         (done),
		.result       (result),
		.flags        (flags),
		.pc           (pc)
	);

	initial begin
		clkdbi = 1'b0;
		forever #10 clkdbi = ~clkdbi;
	end

	// ========================================================================
	// failure reporting and compares
	// ========================================================================
	task automatic fail_stop();
		$display("=== FAIL ===");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input lsi_isa_pkg::word_t got,
	                          input lsi_isa_pkg::word_t exp);
		if (got !== exp) begin
			$display("mismatch %s row %0d got 0x%04h exp 0x%04h", name, cur_row, got, exp);
			fail_stop();
		end
	endtask

	task automatic check_cc(input string name, input lsi_isa_pkg::cc_t got,
	                        input lsi_isa_pkg::cc_t exp);
		if (got !== exp) begin
			$display("mismatch %s row %0d got 0x%01h exp 0x%01h", name, cur_row, got, exp);
			fail_stop();
		end
	endtask

	// ========================================================================
	// reference model, one task per instruction class
	// ========================================================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output lsi_isa_pkg::word_t w);
		w = 16'h0000;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_next(lfsr_q);
			w = {w[14:0], lfsr_q[0]};
		end
	endtask

	task automatic push_row(input lsi_isa_pkg::word_t ins, input lsi_isa_pkg::word_t lit,
	                        input lsi_isa_pkg::word_t res);
		rows.push_back(row_t'({ins, lit, res, m_cc, m_reg[7]}));
	endtask

	task automatic dop(input lsi_isa_pkg::dop_code_t code, input logic imm,
	                   input lsi_isa_pkg::reg_idx_t s, input lsi_isa_pkg::reg_idx_t d,
	                   input lsi_isa_pkg::word_t lit);
		lsi_isa_pkg::word_t src, dst, r, ins;
		int                 ss, sd, us, ud, sres;
		logic               c;
		src  = imm ? lit : m_reg[s];
		dst  = m_reg[d];
		ss   = int'($signed(src));
		sd   = int'($signed(dst));
		us   = int'(src);
		ud   = int'(dst);
		sres = 0;           // logic ops never overflow
		c    = m_cc[0];
		ins  = imm ? {code, 6'o27, 3'o0, d} : {code, 3'o0, s, 3'o0, d};
		case (code)
			lsi_isa_pkg::DOP_ADD: begin
				r    = src + dst;
				sres = sd + ss;
				c    = (ud + us) > 65535;
			end
			lsi_isa_pkg::DOP_SUB: begin  // dst - src, c is borrow
				r    = dst - src;
				sres = sd - ss;
				c    = us > ud;
			end
			lsi_isa_pkg::DOP_CMP: begin  // src - dst
				r    = src - dst;
				sres = ss - sd;
				c    = ud > us;
			end
			lsi_isa_pkg::DOP_BIC: r = dst & ~src;
			lsi_isa_pkg::DOP_BIS: r = dst | src;
			default:              r = src;
		endcase
		if (code != lsi_isa_pkg::DOP_CMP) begin
			m_reg[d] = r;
		end
		m_cc = {r[15], r == 16'h0000, (sres > 32767) || (sres < -32768), c};
		m_reg[7] = m_reg[7] + (imm ? 16'd4 : 16'd2);
		push_row(ins, lit, r);
	endtask

	task automatic sop(input lsi_isa_pkg::sop_code_t code, input lsi_isa_pkg::reg_idx_t d);
		lsi_isa_pkg::word_t x, r;
		logic               v, c;
		x = m_reg[d];
		r = x;
		v = 1'b0;
		c = m_cc[0];        // inc, dec and tst keep it
		case (code)
			lsi_isa_pkg::SOP_CLR: begin r = 16'h0000; c = 1'b0; end
			lsi_isa_pkg::SOP_COM: begin r = ~x; c = 1'b1; end
			lsi_isa_pkg::SOP_INC: begin r = x + 16'd1; v = (x == 16'h7fff); end
			lsi_isa_pkg::SOP_DEC: begin r = x - 16'd1; v = (x == 16'h8000); end
			lsi_isa_pkg::SOP_NEG: begin
				r = 16'h0000 - x;
				v = (x == 16'h8000);
				c = (x != 16'h0000);
			end
			default:              r = x;
		endcase
		if (code != lsi_isa_pkg::SOP_TST) begin
			m_reg[d] = r;
		end
		m_cc = {r[15], r == 16'h0000, v, c};
		m_reg[7] = m_reg[7] + 16'd2;
		push_row({code, 3'o0, d}, 16'h0000, r);
	endtask

	task automatic br(input lsi_isa_pkg::branch_sel_t sel, input lsi_isa_pkg::br_ofs_t ofs);
		logic n, z, v, c, go;
		{n, z, v, c} = m_cc;
		case (sel)
			lsi_isa_pkg::BR_BR:   go = 1'b1;
			lsi_isa_pkg::BR_BNE:  go = !z;
			lsi_isa_pkg::BR_BEQ:  go = z;
			lsi_isa_pkg::BR_BGE:  go = (n == v);
			lsi_isa_pkg::BR_BLT:  go = (n != v);
			lsi_isa_pkg::BR_BGT:  go = !z && (n == v);
			lsi_isa_pkg::BR_BLE:  go = z || (n != v);
			lsi_isa_pkg::BR_BPL:  go = !n;
			lsi_isa_pkg::BR_BMI:  go = n;
			lsi_isa_pkg::BR_BHI:  go = !c && !z;
			lsi_isa_pkg::BR_BLOS: go = c || z;
			lsi_isa_pkg::BR_BVC:  go = !v;
			lsi_isa_pkg::BR_BVS:  go = v;
			lsi_isa_pkg::BR_BCC:  go = !c;
			default:              go = c;    // bcs
		endcase
		m_reg[7] = lsi_isa_pkg::word_t'(int'(m_reg[7]) + 2 + (go ? 2 * int'($signed(ofs)) : 0));
		push_row({sel[3], 4'b0000, sel[2:0], ofs}, 16'h0000, m_reg[7]);
	endtask

	task automatic ccop(input logic set, input lsi_isa_pkg::cc_t bits);
		m_cc = set ? (m_cc | bits) : (m_cc & ~bits);
		m_reg[7] = m_reg[7] + 16'd2;
		push_row({11'o0005, set, bits}, 16'h0000, 16'h0000);
	endtask

	task automatic build_table();
		lsi_isa_pkg::word_t w;
		lfsr_q = 32'h303b;
		m_reg = '{default: 16'h0000};
		m_reg[7] = START_PC;
		m_cc = 4'h0;
		ccop(1'b0, 4'hf);                                  // pc right after reset
		rand_bits(16, w);
		dop(lsi_isa_pkg::DOP_MOV, 1'b1, 3'd0, 3'd0, w);
		dop(lsi_isa_pkg::DOP_MOV, 1'b1, 3'd0, 3'd1, 16'h7fff);
		dop(lsi_isa_pkg::DOP_ADD, 1'b1, 3'd0, 3'd1, 16'h0001);  // signed overflow
		dop(lsi_isa_pkg::DOP_MOV, 1'b1, 3'd0, 3'd2, 16'hffff);
		dop(lsi_isa_pkg::DOP_ADD, 1'b1, 3'd0, 3'd2, 16'h0001);  // carry out to zero
		dop(lsi_isa_pkg::DOP_SUB, 1'b1, 3'd0, 3'd2, 16'h0001);  // borrow
		dop(lsi_isa_pkg::DOP_SUB, 1'b0, 3'd1, 3'd3, 16'h0000);
		rand_bits(16, w);
		dop(lsi_isa_pkg::DOP_BIS, 1'b1, 3'd0, 3'd4, w);
		rand_bits(16, w);
		dop(lsi_isa_pkg::DOP_BIC, 1'b1, 3'd0, 3'd4, w);
		dop(lsi_isa_pkg::DOP_MOV, 1'b0, 3'd4, 3'd5, 16'h0000);  // read back
		dop(lsi_isa_pkg::DOP_MOV, 1'b0, 3'd0, 3'd6, 16'h0000);
		for (int k = 0; k < 6; k++) begin
			rand_bits(16, w);
			dop(lsi_isa_pkg::DOP_ADD, 1'b1, 3'd0, 3'd0, w);
			rand_bits(16, w);
			dop(lsi_isa_pkg::DOP_SUB, 1'b1, 3'd0, 3'd3, w);
			dop(lsi_isa_pkg::DOP_ADD, 1'b0, 3'd0, 3'd3, 16'h0000);
		end
		// flag only instructions, destination checked by the mov after
		rand_bits(16, w);
		dop(lsi_isa_pkg::DOP_CMP, 1'b1, 3'd0, 3'd1, w);
		dop(lsi_isa_pkg::DOP_CMP, 1'b0, 3'd1, 3'd1, 16'h0000);
		dop(lsi_isa_pkg::DOP_CMP, 1'b0, 3'd2, 3'd0, 16'h0000);
		dop(lsi_isa_pkg::DOP_MOV, 1'b0, 3'd1, 3'd5, 16'h0000);
		sop(lsi_isa_pkg::SOP_TST, 3'd2);
		sop(lsi_isa_pkg::SOP_TST, 3'd1);
		dop(lsi_isa_pkg::DOP_MOV, 1'b0, 3'd2, 3'd5, 16'h0000);
		sop(lsi_isa_pkg::SOP_CLR, 3'd3);
		sop(lsi_isa_pkg::SOP_COM, 3'd3);
		sop(lsi_isa_pkg::SOP_INC, 3'd3);                   // wraps to 0, c kept
		sop(lsi_isa_pkg::SOP_DEC, 3'd3);
		sop(lsi_isa_pkg::SOP_NEG, 3'd3);
		sop(lsi_isa_pkg::SOP_NEG, 3'd1);
		sop(lsi_isa_pkg::SOP_CLR, 3'd6);
		sop(lsi_isa_pkg::SOP_NEG, 3'd6);                   // zero clears c
		dop(lsi_isa_pkg::DOP_MOV, 1'b1, 3'd0, 3'd5, 16'h7fff);
		sop(lsi_isa_pkg::SOP_INC, 3'd5);
		sop(lsi_isa_pkg::SOP_DEC, 3'd5);
		for (int k = 0; k < 4; k++) begin
			sop(lsi_isa_pkg::SOP_NEG, 3'd0);
			sop(lsi_isa_pkg::SOP_COM, 3'd0);
			sop(lsi_isa_pkg::SOP_INC, 3'd0);
			sop(lsi_isa_pkg::SOP_DEC, 3'd4);
		end
		// every branch code against every flag combination
		for (int f = 0; f < 16; f++) begin
			ccop(1'b0, 4'hf);
			ccop(1'b1, lsi_isa_pkg::cc_t'(f));
			for (int b = 1; b < 16; b++) begin
				rand_bits(8, w);
				br(lsi_isa_pkg::branch_sel_t'(b), w[7:0]);
			end
		end
		ccop(1'b1, 4'b0101);
		ccop(1'b0, 4'b0100);
		ccop(1'b1, 4'b1010);
		ccop(1'b0, 4'b0001);
		ccop(1'b0, 4'b0000);
	endtask

	// ========================================================================
	// stimulus
	// ========================================================================
	task automatic apply_row(input row_t r);
		int wait_cnt;
		instr_strobe = 1'b1;
		instr        = r.instr;
		literal      = r.lit;                  // stays until the next row
		@(posedge clkdbi);
		#2;
		instr_strobe = 1'b0;
		wait_cnt     = 0;
		while (!done && (wait_cnt < MAX_WAIT)) begin
			@(posedge clkdbi);
			#2;
			wait_cnt++;
		end
		if (!done) begin
			$display("no done within %0d cycles of the strobe on row %0d", MAX_WAIT, cur_row);
			fail_stop();
		end else begin
			check_word("result", result, r.res);
			check_cc("flags", flags, r.cc);
			check_word("pc", pc, r.pc);
			@(posedge clkdbi);                 // back to idle
			#2;
		end
	endtask

	initial begin
		reset_n      = 1'b0;
		instr_strobe = 1'b0;
		instr        = 16'h0000;
		literal      = 16'h0000;
		built        = 1'b0;
		cur_row      = 0;
		build_table();
		built = 1'b1;
		repeat (RESET_CYCLES) @(posedge clkdbi);
		#2;
		reset_n = 1'b1;
		@(posedge clkdbi);
		#2;
		for (int i = 0; i < rows.size(); i++) begin
			cur_row = i;
			apply_row(rows[i]);
		end
		$display("=== PASS ===");
		$finish;
	end

	// watchdog sized from the table
	initial begin
		wait (built == 1'b1);
		repeat (rows.size() * 10 + RESET_CYCLES + 2) @(posedge clkdbi);
		$display("watchdog expired before the stimulus table finished");
		fail_stop();
	end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/10ps

module alu (
	input  lsi_ctrl_pkg::alu_op_t  op,
	input  lsi_isa_pkg::word_t     a,       // destination operand
	input  lsi_isa_pkg::word_t     b,       // source operand
	input  logic                   c_in,    // stored carry
	output lsi_isa_pkg::word_t     result,
	output lsi_isa_pkg::cc_t       cc_out,
	output lsi_isa_pkg::cc_t       cc_mask
);

	logic [16:0]        sum_ab;   // a + b with carry out
	logic [16:0]        diff_ab;  // a - b, bit 16 is the borrow
	logic [16:0]        diff_ba;  // b - a for cmp
	lsi_isa_pkg::word_t res;
	logic               v;
	logic               c;
	logic               keep_c;

	assign sum_ab  = {1'b0, a} + {1'b0, b};
	assign diff_ab = {1'b0, a} - {1'b0, b};
	assign diff_ba = {1'b0, b} - {1'b0, a};

	// ========================================================================
	// result, v and c per operation
	// ========================================================================
	always_comb begin
		res    = a;
		v      = 1'b0;
		c      = c_in;
		keep_c = 1'b0;
		unique case (op)
			lsi_ctrl_pkg::ALU_MOV: begin
				res    = b;
				keep_c = 1'b1;
			end
			lsi_ctrl_pkg::ALU_ADD: begin
				res = sum_ab[15:0];
				c   = sum_ab[16];
				v   = (a[15] == b[15]) && (sum_ab[15] != a[15]);
			end
			lsi_ctrl_pkg::ALU_SUB: begin  // dst - src
				res = diff_ab[15:0];
				c   = diff_ab[16];
				v   = (a[15] != b[15]) && (diff_ab[15] != a[15]);
			end
			lsi_ctrl_pkg::ALU_CMP: begin  // src - dst, result not written
				res = diff_ba[15:0];
				c   = diff_ba[16];
				v   = (a[15] != b[15]) && (diff_ba[15] != b[15]);
			end
			lsi_ctrl_pkg::ALU_BIC: begin
				res    = a & ~b;
				keep_c = 1'b1;
			end
			lsi_ctrl_pkg::ALU_BIS: begin
				res    = a | b;
				keep_c = 1'b1;
			end
			lsi_ctrl_pkg::ALU_CLR: begin
				res = '0;
				c   = 1'b0;
			end
			lsi_ctrl_pkg::ALU_COM: begin
				res = ~a;
				c   = 1'b1;
			end
			lsi_ctrl_pkg::ALU_INC: begin
				res    = a + 16'd1;
				v      = (a == 16'o077777);  // largest positive rolls over
				keep_c = 1'b1;
			end
			lsi_ctrl_pkg::ALU_DEC: begin
				res    = a - 16'd1;
				v      = (a == 16'o100000);
				keep_c = 1'b1;
			end
			lsi_ctrl_pkg::ALU_NEG: begin
				res = 16'h0000 - a;
				v   = (a == 16'o100000);     // -32768 has no positive
				c   = (a != 16'h0000);
			end
			lsi_ctrl_pkg::ALU_TST: begin
				keep_c = 1'b1;
			end
			default: begin
				res = '0;
			end
		endcase
	end

	assign result  = res;
	assign cc_out  = {res[15], (res == 16'h0000), v, c};
	assign cc_mask = {3'b111, ~keep_c};  // n z v always written

endmodule

// ==== verilog/cond_codes.sv ====
`timescale 1ns/10ps

module cond_codes (
	input  logic                      clkdbi,
	input  logic                      reset_n,
	input  logic                      cc_load,
	input  lsi_isa_pkg::cc_t          cc_in,
	input  lsi_isa_pkg::cc_t          cc_mask,
	input  logic                      cc_set,
	input  logic                      cc_clear,
	input  lsi_isa_pkg::cc_t          cc_bits,
	input  lsi_isa_pkg::branch_sel_t  branch_sel,
	output lsi_isa_pkg::cc_t          flags,
	output logic                      taken
);

	lsi_isa_pkg::cc_t flags_q;
	logic             n, z, v, c;
	logic             cond;

	always_ff @(posedge clkdbi) begin
		if (!reset_n) begin
			flags_q <= '0;
		end else if (cc_load) begin
			flags_q <= (flags_q & ~cc_mask) | (cc_in & cc_mask);
		end else if (cc_set) begin
			flags_q <= flags_q | cc_bits;   // sen .. scc
		end else if (cc_clear) begin
			flags_q <= flags_q & ~cc_bits;  // cln .. clc
		end
	end

	assign flags = flags_q;
	assign {n, z, v, c} = flags_q;

	// condition groups of the branch table, true sense
	always_comb begin
		unique case (branch_sel[3:1])
			3'd0:    cond = 1'b1;
			3'd1:    cond = z;
			3'd2:    cond = n ^ v;
			3'd3:    cond = (n ^ v) | z;
			3'd4:    cond = n;
			3'd5:    cond = c | z;
			3'd6:    cond = v;
			default: cond = c;
		endcase
	end

	// bit 8 clear inverts the sense
	assign taken = cond ^ ~branch_sel[0];

endmodule

// ==== verilog/lsi_core.sv ====
`timescale 1ns/10ps

module lsi_core #(
	parameter lsi_isa_pkg::word_t RESET_PC = 16'o000000
) (
	input  logic                clkdbi,
	input  logic                reset_n,
	input  logic                instr_strobe,
	input  lsi_isa_pkg::word_t  instr,
	input  lsi_isa_pkg::word_t  literal,   // held until done
	output logic                done,
	output lsi_isa_pkg::word_t  result,
	output lsi_isa_pkg::cc_t    flags,
	output lsi_isa_pkg::word_t  pc
);

	lsi_isa_pkg::reg_idx_t    rd_a_idx, rd_b_idx, wr_idx;
	lsi_isa_pkg::word_t       rd_a, rd_b, alu_b;
	lsi_isa_pkg::cc_t         cc_out, cc_mask, cc_bits;
	lsi_isa_pkg::branch_sel_t branch_sel;
	lsi_isa_pkg::br_ofs_t     branch_ofs;
	lsi_ctrl_pkg::alu_op_t    alu_op;
	lsi_ctrl_pkg::src_sel_t   src_sel;
	logic                     wr_en, cc_load, cc_set, cc_clear, taken;
	logic                     pc_step, pc_extra, pc_branch;

	// ========================================================================
	// control
	// ========================================================================
	sequencer u_sequencer (
		.clkdbi       (clkdbi),
		.reset_n      (reset_n),
		.instr_strobe (instr_strobe),
		.instr        (instr),
		.taken        (taken),
		.rd_a_idx     (rd_a_idx),
		.rd_b_idx     (rd_b_idx),
		.wr_en        (wr_en),
		.wr_idx       (wr_idx),
		.alu_op       (alu_op),
		.src_sel      (src_sel),
		.cc_load      (cc_load),
		.cc_set       (cc_set),
		.cc_clear     (cc_clear),
		.cc_bits      (cc_bits),
		.branch_sel   (branch_sel),
		.branch_ofs   (branch_ofs),
		.pc_step      (pc_step),
		.pc_extra     (pc_extra),
		.pc_branch    (pc_branch),
		.done         (done)
	);

	// ========================================================================
	// datapath
	// ========================================================================
	reg_file #(
		.RESET_PC (RESET_PC)
	) u_reg_file (
		.clkdbi     (clkdbi),
		.reset_n    (reset_n),
		.rd_a_idx   (rd_a_idx),
		.rd_b_idx   (rd_b_idx),
		.rd_a       (rd_a),
		.rd_b       (rd_b),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.wr_data    (result),
		.pc_step    (pc_step),
		.pc_extra   (pc_extra),
		.pc_branch  (pc_branch),
		.branch_ofs (branch_ofs),
		.pc         (pc)
	);

	// immediate source bypasses the register file
	assign alu_b = (src_sel == lsi_ctrl_pkg::SRC_LIT) ? literal : rd_b;

	alu u_alu (
		.op      (alu_op),
		.a       (rd_a),
		.b       (alu_b),
		.c_in    (flags[0]),
		.result  (result),
		.cc_out  (cc_out),
		.cc_mask (cc_mask)
	);

	cond_codes u_cond_codes (
		.clkdbi     (clkdbi),
		.reset_n    (reset_n),
		.cc_load    (cc_load),
		.cc_in      (cc_out),
		.cc_mask    (cc_mask),
		.cc_set     (cc_set),
		.cc_clear   (cc_clear),
		.cc_bits    (cc_bits),
		.branch_sel (branch_sel),
		.flags      (flags),
		.taken      (taken)
	);

endmodule

// ==== verilog/lsi_ctrl_pkg.sv ====
package lsi_ctrl_pkg;

	// ========================================================================
	// sequencer
	// ========================================================================
	typedef enum logic [1:0] {
		IDLE,       // waiting for instr_strobe
		DECODE,
		EXECUTE,    // flags and pc update on this edge
		WRITEBACK   // register write, done is high
	} seq_state_t;

	// decoded instruction class
	typedef enum logic [2:0] {
		CLS_NOP,    // unsupported, only the pc moves
		CLS_DOP,
		CLS_SOP,
		CLS_BR,
		CLS_CC
	} instr_class_t;

	// ========================================================================
	// datapath controls
	// ========================================================================
	typedef enum logic [3:0] {
		ALU_MOV,
		ALU_ADD,
		ALU_SUB,
		ALU_CMP,
		ALU_BIC,
		ALU_BIS,
		ALU_CLR,
		ALU_COM,
		ALU_INC,
		ALU_DEC,
		ALU_NEG,
		ALU_TST
	} alu_op_t;

	// second alu operand
	typedef enum logic {SRC_REG, SRC_LIT} src_sel_t;

endpackage

// ==== verilog/lsi_isa_pkg.sv ====
package lsi_isa_pkg;

	// ========================================================================
	// word and field types
	// ========================================================================
	typedef logic [15:0] word_t;        // data or instruction word
	typedef logic [2:0]  reg_idx_t;     // r0..r7, r7 is the pc
	typedef logic [3:0]  cc_t;          // n z v c
	typedef logic [3:0]  branch_sel_t;  // {instr[15], instr[10:8]}
	typedef logic [7:0]  br_ofs_t;      // signed word offset of a branch
	typedef logic [3:0]  dop_code_t;    // instr[15:12]
	typedef logic [9:0]  sop_code_t;    // instr[15:6]

	localparam reg_idx_t PC_IDX = 3'd7;

	// operand mode fields
	localparam logic [2:0] MODE_REG = 3'o0;
	localparam logic [5:0] SRC_IMM  = 6'o27;  // (r7)+ fetches the literal

	// ========================================================================
	// double operand codes
	// ========================================================================
	localparam dop_code_t DOP_MOV = 4'o01;
	localparam dop_code_t DOP_CMP = 4'o02;
	localparam dop_code_t DOP_BIC = 4'o04;
	localparam dop_code_t DOP_BIS = 4'o05;
	localparam dop_code_t DOP_ADD = 4'o06;
	localparam dop_code_t DOP_SUB = 4'o16;

	// single operand, word forms only
	localparam sop_code_t SOP_CLR = 10'o0050;
	localparam sop_code_t SOP_COM = 10'o0051;
	localparam sop_code_t SOP_INC = 10'o0052;
	localparam sop_code_t SOP_DEC = 10'o0053;
	localparam sop_code_t SOP_NEG = 10'o0054;
	localparam sop_code_t SOP_TST = 10'o0057;

	// 000240..000277, bit 4 set/clear, bits 3:0 pick n z v c
	localparam logic [10:0] CCOP_PATTERN = 11'o0005;

	// ========================================================================
	// branch table
	// ========================================================================
	// upper three bits pick the condition, bit 0 (instr bit 8) the sense
	localparam branch_sel_t BR_BR   = 4'h1;
	localparam branch_sel_t BR_BNE  = 4'h2;
	localparam branch_sel_t BR_BEQ  = 4'h3;
	localparam branch_sel_t BR_BGE  = 4'h4;
	localparam branch_sel_t BR_BLT  = 4'h5;
	localparam branch_sel_t BR_BGT  = 4'h6;
	localparam branch_sel_t BR_BLE  = 4'h7;
	localparam branch_sel_t BR_BPL  = 4'h8;
	localparam branch_sel_t BR_BMI  = 4'h9;
	localparam branch_sel_t BR_BHI  = 4'ha;
	localparam branch_sel_t BR_BLOS = 4'hb;
	localparam branch_sel_t BR_BVC  = 4'hc;
	localparam branch_sel_t BR_BVS  = 4'hd;
	localparam branch_sel_t BR_BCC  = 4'he;
	localparam branch_sel_t BR_BCS  = 4'hf;

endpackage

// ==== verilog/reg_file.sv ====
`timescale 1ns/10ps

module reg_file #(
	parameter lsi_isa_pkg::word_t RESET_PC = 16'o000000
) (
	input  logic                   clkdbi,
	input  logic                   reset_n,
	input  lsi_isa_pkg::reg_idx_t  rd_a_idx,
	input  lsi_isa_pkg::reg_idx_t  rd_b_idx,
	output lsi_isa_pkg::word_t     rd_a,
	output lsi_isa_pkg::word_t     rd_b,
	input  logic                   wr_en,
	input  lsi_isa_pkg::reg_idx_t  wr_idx,
	input  lsi_isa_pkg::word_t     wr_data,
	input  logic                   pc_step,
	input  logic                   pc_extra,
	input  logic                   pc_branch,
	input  lsi_isa_pkg::br_ofs_t   branch_ofs,
	output lsi_isa_pkg::word_t     pc
);

	lsi_isa_pkg::word_t regs [0:7];
	lsi_isa_pkg::word_t pc_inc;
	lsi_isa_pkg::word_t branch_disp;
	lsi_isa_pkg::word_t pc_next;

	// combinational read ports
	assign rd_a = regs[rd_a_idx];
	assign rd_b = regs[rd_b_idx];
	assign pc   = regs[lsi_isa_pkg::PC_IDX];

	// one instruction word, plus the literal word when fetched
	assign pc_inc = pc_extra ? 16'd4 : 16'd2;

	// byte offset: sign extended, shifted left by one
	assign branch_disp = {{7{branch_ofs[7]}}, branch_ofs, 1'b0};

	assign pc_next = pc + pc_inc + (pc_branch ? branch_disp : 16'h0000);

	always_ff @(posedge clkdbi) begin
		if (!reset_n) begin
			for (int i = 0; i < 7; i++) begin
				regs[i] <= '0;
			end
			regs[lsi_isa_pkg::PC_IDX] <= RESET_PC;
		end else begin
			// r7 moves only through the step path
			if (wr_en && (wr_idx != lsi_isa_pkg::PC_IDX)) begin
				regs[wr_idx] <= wr_data;
			end
			if (pc_step) begin
				regs[lsi_isa_pkg::PC_IDX] <= pc_next;
			end
		end
	end

endmodule

// ==== verilog/sequencer.sv ====
`timescale 1ns/10ps

module sequencer (
	input  logic                      clkdbi,
	input  logic                      reset_n,
	input  logic                      instr_strobe,
	input  lsi_isa_pkg::word_t        instr,
	input  logic                      taken,
	output lsi_isa_pkg::reg_idx_t     rd_a_idx,
	output lsi_isa_pkg::reg_idx_t     rd_b_idx,
	output logic                      wr_en,
	output lsi_isa_pkg::reg_idx_t     wr_idx,
	output lsi_ctrl_pkg::alu_op_t     alu_op,
	output lsi_ctrl_pkg::src_sel_t    src_sel,
	output logic                      cc_load,
	output logic                      cc_set,
	output logic                      cc_clear,
	output lsi_isa_pkg::cc_t          cc_bits,
	output lsi_isa_pkg::branch_sel_t  branch_sel,
	output lsi_isa_pkg::br_ofs_t      branch_ofs,
	output logic                      pc_step,
	output logic                      pc_extra,
	output logic                      pc_branch,
	output logic                      done
);

	lsi_ctrl_pkg::seq_state_t   state, state_nxt;
	lsi_ctrl_pkg::instr_class_t iclass;
	lsi_ctrl_pkg::alu_op_t      dop_op, sop_op;
	lsi_isa_pkg::word_t         instr_q;
	logic                       dop_hit, sop_hit;
	logic                       src_imm, src_ok, dst_ok;
	logic                       is_branch, is_ccop, writes;

	// ========================================================================
	// state machine
	// ========================================================================
	always_comb begin
		unique case (state)
			lsi_ctrl_pkg::IDLE:    state_nxt = instr_strobe ? lsi_ctrl_pkg::DECODE
			                                                : lsi_ctrl_pkg::IDLE;
			lsi_ctrl_pkg::DECODE:  state_nxt = lsi_ctrl_pkg::EXECUTE;
			lsi_ctrl_pkg::EXECUTE: state_nxt = lsi_ctrl_pkg::WRITEBACK;
			default:               state_nxt = lsi_ctrl_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clkdbi) begin
		if (!reset_n) begin
			state <= lsi_ctrl_pkg::IDLE;
			done  <= 1'b0;
		end else begin
			state <= state_nxt;
			done  <= (state == lsi_ctrl_pkg::EXECUTE);  // high during writeback
		end
	end

	// strobes outside idle are dropped
	always_ff @(posedge clkdbi) begin
		if ((state == lsi_ctrl_pkg::IDLE) && instr_strobe) begin
			instr_q <= instr;
		end
	end

	// ========================================================================
	// decode
	// ========================================================================
	always_comb begin
		dop_hit = 1'b1;
		sop_hit = 1'b1;
		dop_op  = lsi_ctrl_pkg::ALU_MOV;
		sop_op  = lsi_ctrl_pkg::ALU_CLR;
		case (instr_q[15:12])
			lsi_isa_pkg::DOP_MOV: dop_op = lsi_ctrl_pkg::ALU_MOV;
			lsi_isa_pkg::DOP_CMP: dop_op = lsi_ctrl_pkg::ALU_CMP;
			lsi_isa_pkg::DOP_BIC: dop_op = lsi_ctrl_pkg::ALU_BIC;
			lsi_isa_pkg::DOP_BIS: dop_op = lsi_ctrl_pkg::ALU_BIS;
			lsi_isa_pkg::DOP_ADD: dop_op = lsi_ctrl_pkg::ALU_ADD;
			lsi_isa_pkg::DOP_SUB: dop_op = lsi_ctrl_pkg::ALU_SUB;
			default:              dop_hit = 1'b0;
		endcase
		case (instr_q[15:6])
			lsi_isa_pkg::SOP_CLR: sop_op = lsi_ctrl_pkg::ALU_CLR;
			lsi_isa_pkg::SOP_COM: sop_op = lsi_ctrl_pkg::ALU_COM;
			lsi_isa_pkg::SOP_INC: sop_op = lsi_ctrl_pkg::ALU_INC;
			lsi_isa_pkg::SOP_DEC: sop_op = lsi_ctrl_pkg::ALU_DEC;
			lsi_isa_pkg::SOP_NEG: sop_op = lsi_ctrl_pkg::ALU_NEG;
			lsi_isa_pkg::SOP_TST: sop_op = lsi_ctrl_pkg::ALU_TST;
			default:              sop_hit = 1'b0;
		endcase
	end

	assign src_imm   = (instr_q[11:6] == lsi_isa_pkg::SRC_IMM);
	assign src_ok    = (instr_q[11:9] == lsi_isa_pkg::MODE_REG) || src_imm;
	assign dst_ok    = (instr_q[5:3] == lsi_isa_pkg::MODE_REG);
	assign is_branch = (instr_q[14:11] == 4'b0000) && ({instr_q[15], instr_q[10:8]} != 4'h0);
	assign is_ccop   = (instr_q[15:5] == lsi_isa_pkg::CCOP_PATTERN);

	always_comb begin
		if (dop_hit && src_ok && dst_ok) begin
			iclass = lsi_ctrl_pkg::CLS_DOP;
		end else if (sop_hit && dst_ok) begin
			iclass = lsi_ctrl_pkg::CLS_SOP;
		end else if (is_branch) begin
			iclass = lsi_ctrl_pkg::CLS_BR;
		end else if (is_ccop) begin
			iclass = lsi_ctrl_pkg::CLS_CC;
		end else begin
			iclass = lsi_ctrl_pkg::CLS_NOP;
		end
	end

	// branches pass the new pc through as a mov, others clear to 0
	always_comb begin
		unique case (iclass)
			lsi_ctrl_pkg::CLS_DOP: alu_op = dop_op;
			lsi_ctrl_pkg::CLS_SOP: alu_op = sop_op;
			lsi_ctrl_pkg::CLS_BR:  alu_op = lsi_ctrl_pkg::ALU_MOV;
			default:               alu_op = lsi_ctrl_pkg::ALU_CLR;
		endcase
	end

	// ========================================================================
	// datapath steering
	// ========================================================================
	assign writes = ((iclass == lsi_ctrl_pkg::CLS_DOP) && (dop_op != lsi_ctrl_pkg::ALU_CMP))
	             || ((iclass == lsi_ctrl_pkg::CLS_SOP) && (sop_op != lsi_ctrl_pkg::ALU_TST));

	assign rd_a_idx = instr_q[2:0];  // destination
	assign rd_b_idx = (iclass == lsi_ctrl_pkg::CLS_BR) ? lsi_isa_pkg::PC_IDX : instr_q[8:6];
	assign wr_idx   = instr_q[2:0];
	assign wr_en    = (state == lsi_ctrl_pkg::WRITEBACK) && writes;
	assign src_sel  = ((iclass == lsi_ctrl_pkg::CLS_DOP) && src_imm) ? lsi_ctrl_pkg::SRC_LIT
	                                                                 : lsi_ctrl_pkg::SRC_REG;

	assign cc_load  = (state == lsi_ctrl_pkg::EXECUTE)
	               && ((iclass == lsi_ctrl_pkg::CLS_DOP) || (iclass == lsi_ctrl_pkg::CLS_SOP));
	assign cc_set   = (state == lsi_ctrl_pkg::EXECUTE) && (iclass == lsi_ctrl_pkg::CLS_CC)
	               && instr_q[4];
	assign cc_clear = (state == lsi_ctrl_pkg::EXECUTE) && (iclass == lsi_ctrl_pkg::CLS_CC)
	               && !instr_q[4];
	assign cc_bits  = instr_q[3:0];

	assign branch_sel = {instr_q[15], instr_q[10:8]};
	assign branch_ofs = instr_q[7:0];
	assign pc_step    = (state == lsi_ctrl_pkg::EXECUTE);  // every class, nop too
	assign pc_extra   = (iclass == lsi_ctrl_pkg::CLS_DOP) && src_imm;
	assign pc_branch  = pc_step && (iclass == lsi_ctrl_pkg::CLS_BR) && taken;

endmodule
